// ==== files.f ====
hw/bank_pkg.sv
hw/bank_ram_1r1w.sv
hw/bank_req_decoder.sv
hw/bank_read_collect.sv
hw/banked_mem_top.sv
bench/banked_mem_tb.sv

// ==== Bender.yml ====
package:
  name: banked_mem

sources:
  # design
  - files:
      - hw/bank_pkg.sv
      - hw/bank_ram_1r1w.sv
      - hw/bank_req_decoder.sv
      - hw/bank_read_collect.sv
      - hw/banked_mem_top.sv

  # testbench
  - target: simulation
    files:
      - bench/banked_mem_tb.sv

// ==== bench/banked_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module banked_mem_tb;

  import bank_pkg::*;

  localparam int unsigned NUM_BANKS = DEF_NUM_BANKS;
  localparam int unsigned ROWS = DEF_ROWS;
  localparam int unsigned DATA_BITS = DEF_DATA_BITS;
  localparam int unsigned LANES = DEF_LANES;
  localparam int unsigned LANE_BITS = DATA_BITS / LANES;
  localparam int unsigned FORWARD = DEF_FORWARD;
  localparam int unsigned WORDS = NUM_BANKS * ROWS;
  localparam int unsigned ADDR_W = $clog2(WORDS);
  // tests run near 900 cycles so the limit keeps a wide margin
  localparam int unsigned MAX_CYCLES = 3000;

  logic                 clock;
  logic                 rst;
  logic                 rd_enable;
  logic [ADDR_W-1:0]    rd_addr;
  logic [DATA_BITS-1:0] rd_data;
  logic                 rd_valid;
  logic [LANES-1:0]     wr_mask;
  logic [ADDR_W-1:0]    wr_addr;
  logic [DATA_BITS-1:0] wr_data;

  // reference copy of the memory contents
  logic [DATA_BITS-1:0] shadow [WORDS];
  logic                 pend_valid;
  logic [DATA_BITS-1:0] pend_data;
  logic [15:0]          lfsr;
  int unsigned          errors;
  int unsigned          checks;
  int unsigned          cycles;

  banked_mem_top u_dut (
    .clock     (clock),
    .rst       (rst),
    .rd_enable (rd_enable),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .wr_mask   (wr_mask),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: simulation did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // galois form with taps for a 16-bit maximal sequence
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hB400;
    end
    return state >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return value;
  endfunction

  // lane 0 is the top slice of the word
  function automatic logic [DATA_BITS-1:0] merge_lanes(input logic [DATA_BITS-1:0] old_word,
                                                       input logic [DATA_BITS-1:0] new_word,
                                                       input logic [LANES-1:0] mask);
    logic [DATA_BITS-1:0] result;
    result = old_word;
    for (int i = 0; i < LANES; i++) begin
      if (mask[i]) begin
        result[DATA_BITS-1-i*LANE_BITS -: LANE_BITS] =
          new_word[DATA_BITS-1-i*LANE_BITS -: LANE_BITS];
      end
    end
    return result;
  endfunction

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAIL t=%0t %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_word(input string name, input logic [DATA_BITS-1:0] expected,
                            input logic [DATA_BITS-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // set the ports for the next edge and note what that edge must return
  task automatic drive(input logic re, input logic [ADDR_W-1:0] raddr,
                       input logic [LANES-1:0] mask, input logic [ADDR_W-1:0] waddr,
                       input logic [DATA_BITS-1:0] wdata);
    logic [DATA_BITS-1:0] exp_word;
    rd_enable = re;
    rd_addr = raddr;
    wr_mask = mask;
    wr_addr = waddr;
    wr_data = wdata;
    pend_valid = re;
    if (re) begin
      exp_word = shadow[raddr];
      if (FORWARD != 0 && mask != '0 && waddr == raddr) begin
        exp_word = merge_lanes(exp_word, wdata, mask);
      end
      pend_data = exp_word;
    end
    if (mask != '0) begin
      shadow[waddr] = merge_lanes(shadow[waddr], wdata, mask);
    end
  endtask

  task automatic drive_idle();
    drive(1'b0, '0, '0, '0, '0);
  endtask

  // read result is due one edge after the strobe
  task automatic advance_and_check();
    @(posedge clock);
    #1;
    check_bit("rd_valid", pend_valid, rd_valid);
    if (pend_valid) begin
      check_word("rd_data", pend_data, rd_data);
    end
    pend_valid = 1'b0;
  endtask

  task automatic reset_phase();
    rst = 1'b1;
    // a read strobe under reset must not raise rd_valid
    drive(1'b1, '0, '0, '0, '0);
    pend_valid = 1'b0;
    repeat (5) begin
      advance_and_check();
    end
    rst = 1'b0;
    drive_idle();
  endtask

  task automatic fill_and_read();
    logic [7:0] a8;
    for (int a = 0; a < WORDS; a++) begin
      a8 = 8'(a);
      drive(1'b0, '0, '1, ADDR_W'(a), {a8, ~a8, a8 ^ 8'h3C, a8 + 8'd7});
      advance_and_check();
    end
    for (int a = 0; a < WORDS; a++) begin
      drive(1'b1, ADDR_W'(a), '0, '0, '0);
      advance_and_check();
    end
    drive_idle();
    advance_and_check();
  endtask

  task automatic lane_masks();
    logic [ADDR_W-1:0] addrs [6];
    logic [LANES-1:0]  masks [6];
    addrs = '{3, 17, 66, 130, 201, 255};
    masks = '{4'b0001, 4'b1000, 4'b0110, 4'b1001, 4'b0100, 4'b0011};
    for (int i = 0; i < 6; i++) begin
      drive(1'b0, '0, masks[i], addrs[i], rand_bits(32));
      advance_and_check();
    end
    for (int i = 0; i < 6; i++) begin
      drive(1'b1, addrs[i], '0, '0, '0);
      advance_and_check();
    end
    // mask bit 0 must land in the top byte
    drive(1'b0, '0, '1, 8'd40, 32'h0000_0000);
    advance_and_check();
    drive(1'b0, '0, 4'b0001, 8'd40, 32'hA5A5_A5A5);
    advance_and_check();
    drive(1'b1, 8'd40, '0, '0, '0);
    advance_and_check();
    check_word("rd_data", 32'hA500_0000, rd_data);
    drive_idle();
    advance_and_check();
  endtask

  task automatic forwarding();
    logic [ADDR_W-1:0] addrs [4];
    addrs = '{7, 12, 97, 254};
    for (int i = 0; i < 4; i++) begin
      drive(1'b1, addrs[i], (i % 2 == 0) ? 4'b0101 : 4'b1010, addrs[i], rand_bits(32));
      advance_and_check();
      // stored word after the write
      drive(1'b1, addrs[i], '0, '0, '0);
      advance_and_check();
    end
    drive_idle();
    advance_and_check();
  endtask

  task automatic independent_ports();
    // same bank first, then different banks
    drive(1'b1, 8'd8, '1, 8'd12, rand_bits(32));
    advance_and_check();
    drive(1'b1, 8'd9, '1, 8'd10, rand_bits(32));
    advance_and_check();
    drive(1'b1, 8'd12, '0, '0, '0);
    advance_and_check();
    drive(1'b1, 8'd10, '0, '0, '0);
    advance_and_check();
    drive_idle();
    advance_and_check();
  endtask

  task automatic valid_control();
    drive(1'b1, 8'd33, '0, '0, '0);
    advance_and_check();
    drive_idle();
    advance_and_check();
    // writes alone never raise rd_valid
    drive(1'b0, '0, 4'b1111, 8'd50, rand_bits(32));
    advance_and_check();
    drive(1'b0, '0, 4'b0010, 8'd51, rand_bits(32));
    advance_and_check();
    drive_idle();
    advance_and_check();
    advance_and_check();
  endtask

  task automatic random_traffic();
    logic              re;
    logic [ADDR_W-1:0] raddr;
    logic [ADDR_W-1:0] waddr;
    logic [LANES-1:0]  mask;
    for (int n = 0; n < 300; n++) begin
      re = rand_bits(1);
      raddr = rand_bits(ADDR_W);
      waddr = rand_bits(ADDR_W);
      mask = rand_bits(LANES);
      // quarter of the cycles hit the read address
      if (rand_bits(2) == 0) begin
        waddr = raddr;
      end
      drive(re, raddr, mask, waddr, rand_bits(DATA_BITS));
      advance_and_check();
    end
    drive_idle();
    advance_and_check();
  endtask

  initial begin
    errors = 0;
    checks = 0;
    cycles = 0;
    lfsr = 16'd17;
    pend_valid = 1'b0;
    pend_data = '0;
    rst = 1'b1;
    rd_enable = 1'b0;
    rd_addr = '0;
    wr_mask = '0;
    wr_addr = '0;
    wr_data = '0;
    for (int a = 0; a < WORDS; a++) begin
      shadow[a] = 'x;
    end
    reset_phase();
    fill_and_read();
    lane_masks();
    forwarding();
    independent_ports();
    valid_control();
    random_traffic();
    $display("summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/banked_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module banked_mem_top #(
  parameter int unsigned NUM_BANKS = bank_pkg::DEF_NUM_BANKS,
  parameter int unsigned ROWS = bank_pkg::DEF_ROWS,
  parameter int unsigned DATA_BITS = bank_pkg::DEF_DATA_BITS,
  parameter int unsigned LANES = bank_pkg::DEF_LANES,
  parameter int unsigned READ_LATENCY = bank_pkg::DEF_READ_LATENCY,
  parameter int unsigned FORWARD = bank_pkg::DEF_FORWARD
) (
  input  logic                                             clock,
  input  logic                                             rst,
  input  logic                                             rd_enable,
  input  logic [bank_pkg::addr_bits(NUM_BANKS, ROWS)-1:0]  rd_addr,
  output logic [DATA_BITS-1:0]                             rd_data,
  output logic                                             rd_valid,
  input  logic [LANES-1:0]                                 wr_mask,
  input  logic [bank_pkg::addr_bits(NUM_BANKS, ROWS)-1:0]  wr_addr,
  input  logic [DATA_BITS-1:0]                             wr_data
);

  import bank_pkg::*;

  localparam int unsigned BANK_W = bank_bits(NUM_BANKS);
  localparam int unsigned ROW_W = addr_bits(1, ROWS);

  logic [NUM_BANKS-1:0]           bank_rd_enable;
  logic [ROW_W-1:0]               bank_rd_row;
  logic [NUM_BANKS*LANES-1:0]     bank_wr_mask;
  logic [ROW_W-1:0]               bank_wr_row;
  logic [BANK_W-1:0]              rd_bank;
  logic [NUM_BANKS*DATA_BITS-1:0] bank_rd_data;

  bank_req_decoder #(
    .NUM_BANKS (NUM_BANKS),
    .ROWS      (ROWS),
    .LANES     (LANES)
  ) u_decoder (
    .rd_enable      (rd_enable),
    .rd_addr        (rd_addr),
    .wr_mask        (wr_mask),
    .wr_addr        (wr_addr),
    .bank_rd_enable (bank_rd_enable),
    .bank_rd_row    (bank_rd_row),
    .bank_wr_mask   (bank_wr_mask),
    .bank_wr_row    (bank_wr_row),
    .rd_bank        (rd_bank)
  );

  // write data goes to every bank, the mask picks one
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    bank_ram_1r1w #(
      .ROWS         (ROWS),
      .DATA_BITS    (DATA_BITS),
      .LANES        (LANES),
      .READ_LATENCY (READ_LATENCY),
      .FORWARD      (FORWARD)
    ) u_bank (
      .clock     (clock),
      .rd_enable (bank_rd_enable[b]),
      .rd_row    (bank_rd_row),
      .rd_data   (bank_rd_data[b*DATA_BITS +: DATA_BITS]),
      .wr_mask   (bank_wr_mask[b*LANES +: LANES]),
      .wr_row    (bank_wr_row),
      .wr_data   (wr_data)
    );
  end

  bank_read_collect #(
    .NUM_BANKS    (NUM_BANKS),
    .DATA_BITS    (DATA_BITS),
    .READ_LATENCY (READ_LATENCY)
  ) u_collect (
    .clock        (clock),
    .rst          (rst),
    .rd_enable    (rd_enable),
    .rd_bank      (rd_bank),
    .bank_rd_data (bank_rd_data),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid)
  );

endmodule

`default_nettype wire

// ==== hw/bank_read_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_read_collect #(
  parameter int unsigned NUM_BANKS = bank_pkg::DEF_NUM_BANKS,
  parameter int unsigned DATA_BITS = bank_pkg::DEF_DATA_BITS,
  parameter int unsigned READ_LATENCY = bank_pkg::DEF_READ_LATENCY
) (
  input  logic                                       clock,
  input  logic                                       rst,
  input  logic                                       rd_enable,
  input  logic [bank_pkg::bank_bits(NUM_BANKS)-1:0]  rd_bank,
  input  logic [NUM_BANKS*DATA_BITS-1:0]             bank_rd_data,
  output logic [DATA_BITS-1:0]                       rd_data,
  output logic                                       rd_valid
);

  import bank_pkg::*;

  localparam int unsigned BANK_W = bank_bits(NUM_BANKS);

  // bank whose word is on the output this cycle
  logic [BANK_W-1:0] sel_bank;

  generate
    if (READ_LATENCY == 1) begin : g_pipe
      logic [BANK_W-1:0] bank_q;
      logic              valid_q;

      // index follows the bank output register
      always_ff @(posedge clock) begin
        bank_q <= rd_bank;
      end

      always_ff @(posedge clock) begin
        if (rst) begin
          valid_q <= 1'b0;
        end else begin
          valid_q <= rd_enable;
        end
      end

      assign sel_bank = bank_q;
      assign rd_valid = valid_q;
    end else begin : g_direct
      // combinational read, answer in the same cycle
      assign sel_bank = rd_bank;
      assign rd_valid = rd_enable;
    end
  endgenerate

  assign rd_data = bank_rd_data[sel_bank*DATA_BITS +: DATA_BITS];

  // an undriven read strobe upstream shows up here
  a_valid_known: assert property (
    @(posedge clock) disable iff (rst) !$isunknown(rd_valid)
  ) else $error("bank_read_collect: rd_valid is unknown");

endmodule

`default_nettype wire

// ==== hw/bank_req_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_req_decoder #(
  parameter int unsigned NUM_BANKS = bank_pkg::DEF_NUM_BANKS,
  parameter int unsigned ROWS = bank_pkg::DEF_ROWS,
  parameter int unsigned LANES = bank_pkg::DEF_LANES
) (
  input  logic                                             rd_enable,
  input  logic [bank_pkg::addr_bits(NUM_BANKS, ROWS)-1:0]  rd_addr,
  input  logic [LANES-1:0]                                 wr_mask,
  input  logic [bank_pkg::addr_bits(NUM_BANKS, ROWS)-1:0]  wr_addr,
  output logic [NUM_BANKS-1:0]                             bank_rd_enable,
  output logic [bank_pkg::addr_bits(1, ROWS)-1:0]          bank_rd_row,
  output logic [NUM_BANKS*LANES-1:0]                       bank_wr_mask,
  output logic [bank_pkg::addr_bits(1, ROWS)-1:0]          bank_wr_row,
  output logic [bank_pkg::bank_bits(NUM_BANKS)-1:0]        rd_bank
);

  import bank_pkg::*;

  localparam int unsigned BANK_W = bank_bits(NUM_BANKS);
  localparam int unsigned ROW_W = addr_bits(1, ROWS);
  localparam int unsigned ADDR_W = addr_bits(NUM_BANKS, ROWS);
  localparam int unsigned WORDS = NUM_BANKS * ROWS;

  logic [BANK_W-1:0] wr_bank;

  // low bits pick the bank, the rest pick the row
  assign rd_bank = BANK_W'(rd_addr);
  assign wr_bank = BANK_W'(wr_addr);
  assign bank_rd_row = ROW_W'(rd_addr >> BANK_W);
  assign bank_wr_row = ROW_W'(wr_addr >> BANK_W);

  // only the addressed bank sees the enable
  always_comb begin
    bank_rd_enable = '0;
    bank_rd_enable[rd_bank] = rd_enable;
  end

  // other banks get an all-zero mask
  always_comb begin
    bank_wr_mask = '0;
    bank_wr_mask[wr_bank*LANES +: LANES] = wr_mask;
  end

  // interleaving needs a power-of-two bank count
  if (NUM_BANKS < 2 || (NUM_BANKS & (NUM_BANKS - 1)) != 0) begin : g_bad_banks
    $error("bank_req_decoder: NUM_BANKS %0d is not a power of two", NUM_BANKS);
  end

  // addresses past the last word would alias into low rows
  always_comb begin
    if (rd_enable) begin
      a_rd_addr_range: assert #0 (rd_addr < ADDR_W'(WORDS - 1) + 1'b1 || WORDS >= (1 << ADDR_W))
        else $error("bank_req_decoder: read address %0d out of range", rd_addr);
    end
    if (|wr_mask) begin
      a_wr_addr_range: assert #0 (wr_addr < ADDR_W'(WORDS - 1) + 1'b1 || WORDS >= (1 << ADDR_W))
        else $error("bank_req_decoder: write address %0d out of range", wr_addr);
    end
  end

endmodule

`default_nettype wire

// ==== hw/bank_ram_1r1w.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_ram_1r1w #(
  parameter int unsigned ROWS = bank_pkg::DEF_ROWS,
  parameter int unsigned DATA_BITS = bank_pkg::DEF_DATA_BITS,
  parameter int unsigned LANES = bank_pkg::DEF_LANES,
  parameter int unsigned READ_LATENCY = bank_pkg::DEF_READ_LATENCY,
  parameter int unsigned FORWARD = bank_pkg::DEF_FORWARD
) (
  input  logic                                     clock,
  input  logic                                     rd_enable,
  input  logic [bank_pkg::addr_bits(1, ROWS)-1:0]  rd_row,
  output logic [DATA_BITS-1:0]                     rd_data,
  input  logic [LANES-1:0]                         wr_mask,
  input  logic [bank_pkg::addr_bits(1, ROWS)-1:0]  wr_row,
  input  logic [DATA_BITS-1:0]                     wr_data
);

  import bank_pkg::*;

  localparam int unsigned ROW_W = addr_bits(1, ROWS);
  localparam int unsigned LANE_BITS = DATA_BITS / LANES;

  // lane 0 sits in the top slice of the word
  logic [0:LANES-1][LANE_BITS-1:0] mem [ROWS];

  logic [0:LANES-1][LANE_BITS-1:0] wr_lanes;
  logic [0:LANES-1][LANE_BITS-1:0] stored_lanes;
  logic [0:LANES-1][LANE_BITS-1:0] rd_lanes;
  logic                            fwd_hit;

  assign wr_lanes = wr_data;

  // byte-enable style write, one slice per mask bit
  always_ff @(posedge clock) begin
    for (int i = 0; i < LANES; i++) begin
      if (wr_mask[i]) begin
        mem[wr_row][i] <= wr_lanes[i];
      end
    end
  end

  assign stored_lanes = mem[rd_row];

  // same row in the same cycle
  assign fwd_hit = (FORWARD != 0) && (wr_row == rd_row);

  always_comb begin
    rd_lanes = stored_lanes;
    for (int i = 0; i < LANES; i++) begin
      if (fwd_hit && wr_mask[i]) begin
        rd_lanes[i] = wr_lanes[i];
      end
    end
  end

  generate
    if (READ_LATENCY == 1) begin : g_reg_out
      // output holds the last read while idle
      always_ff @(posedge clock) begin
        if (rd_enable) begin
          rd_data <= rd_lanes;
        end
      end
    end else begin : g_comb_out
      assign rd_data = rd_lanes;
    end
  endgenerate

  // geometry checks at elaboration
  if (DATA_BITS % LANES != 0) begin : g_bad_lanes
    $error("bank_ram_1r1w: DATA_BITS %0d not a multiple of LANES %0d", DATA_BITS, LANES);
  end

  if (READ_LATENCY > 1) begin : g_bad_latency
    $error("bank_ram_1r1w: READ_LATENCY must be 0 or 1, got %0d", READ_LATENCY);
  end

  // the decoder must never hand a row past the end of the bank
  a_rd_row_range: assert property (
    @(posedge clock) rd_enable |-> (rd_row < ROW_W'(ROWS - 1) + 1'b1 || ROWS >= (1 << ROW_W))
  ) else $error("bank_ram_1r1w: read row %0d out of range", rd_row);

endmodule

`default_nettype wire

// ==== hw/bank_pkg.sv ====
`default_nettype none

package bank_pkg;

  // default geometry of the banked memory
  parameter int unsigned DEF_NUM_BANKS = 4;
  parameter int unsigned DEF_ROWS = 64;
  parameter int unsigned DEF_DATA_BITS = 32;
  parameter int unsigned DEF_LANES = 4;

  // one register stage on the read path
  parameter int unsigned DEF_READ_LATENCY = 1;

  // same-cycle write data reaches the read port
  parameter int unsigned DEF_FORWARD = 1;

  // width of the bank index
  // bank count is a power of two, never below 2
  function automatic int unsigned bank_bits(input int unsigned num_banks);
    int unsigned width;
    width = $clog2(num_banks);
    if (width < 1) begin
      width = 1;
    end
    return width;
  endfunction

  // width of a full word address over all banks
  // with num_banks = 1 this is the row width of one bank
  function automatic int unsigned addr_bits(input int unsigned num_banks,
                                            input int unsigned rows);
    int unsigned width;
    width = $clog2(num_banks * rows);
    if (width < 1) begin
      width = 1;
    end
    return width;
  endfunction

endpackage

`default_nettype wire
